//--- all.f
+incdir+tests
design/ecc_pkg.sv
design/ecc_stage_if.sv
design/ecc_capture.sv
design/ecc_syndrome_decoder.sv
design/ecc_corrector.sv
design/ecc_121_top.sv
tests/ecc_121_tb.sv

//--- design/ecc_121_top.sv
`timescale 1ns/1ps

module ecc_121_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ecc_pkg::DATA_W-1:0]   data_in,
    input  logic [ecc_pkg::CHECK_W-1:0]  parity_in,
    input  logic                         bypass,
    output logic [ecc_pkg::DATA_W-1:0]   data_out,
    output logic [ecc_pkg::CHECK_W-1:0]  parity_out,
    output logic                         sbit_err,
    output logic                         dbit_err
);

    ecc_stage_if cap_to_dec ();
    ecc_stage_if dec_to_cor ();

    // stage 1: encode and syndrome
    ecc_capture u_capture (
        .clk        (clk),
        .rst        (rst),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .parity_out (parity_out),
        .cap_to_dec (cap_to_dec.source)
    );

    // stage 2: classify
    ecc_syndrome_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .cap_to_dec (cap_to_dec.sink),
        .dec_to_cor (dec_to_cor.source)
    );

    // stage 3: fix and drive outputs
    ecc_corrector u_corrector (
        .clk        (clk),
        .rst        (rst),
        .dec_to_cor (dec_to_cor.sink),
        .data_out   (data_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

//--- design/ecc_capture.sv
`timescale 1ns/1ps

module ecc_capture (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ecc_pkg::DATA_W-1:0]   data_in,
    input  logic [ecc_pkg::CHECK_W-1:0]  parity_in,
    input  logic                         bypass,
    output logic [ecc_pkg::CHECK_W-1:0]  parity_out,
    ecc_stage_if.source                  cap_to_dec
);
    import ecc_pkg::*;

    logic [CHECK_W-1:0] check;

    // check bits of the incoming word
    assign check = ecc_encode(data_in);

    always_ff @(posedge clk) begin
        if (rst) begin
            parity_out              <= '0;
            cap_to_dec.data         <= '0;
            cap_to_dec.bypass       <= 1'b0;
            cap_to_dec.syndrome.raw <= '0;
        end else begin
            parity_out              <= check;
            cap_to_dec.data         <= data_in;
            cap_to_dec.bypass       <= bypass;
            cap_to_dec.syndrome.raw <= parity_in ^ check;
        end
    end

    // decode result is produced by the next stage
    assign cap_to_dec.flip     = 1'b0;
    assign cap_to_dec.flip_idx = '0;
    assign cap_to_dec.sbit     = 1'b0;
    assign cap_to_dec.dbit     = 1'b0;

endmodule

//--- design/ecc_corrector.sv
`timescale 1ns/1ps

module ecc_corrector (
    input  logic                       clk,
    input  logic                       rst,
    ecc_stage_if.sink                  dec_to_cor,
    output logic [ecc_pkg::DATA_W-1:0] data_out,
    output logic                       sbit_err,
    output logic                       dbit_err
);
    import ecc_pkg::*;

    logic              correct;
    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] corrected;

    // no correction while bypassed
    assign correct   = dec_to_cor.flip && !dec_to_cor.bypass;
    assign mask      = correct ? (DATA_W'(1) << dec_to_cor.flip_idx) : '0;
    assign corrected = dec_to_cor.data ^ mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_out <= '0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            data_out <= corrected;
            sbit_err <= dec_to_cor.sbit && !dec_to_cor.bypass;
            dbit_err <= dec_to_cor.dbit && !dec_to_cor.bypass;
        end
    end

    // decoder must never point past the data word
    a_idx_in_range: assert property (@(posedge clk) disable iff (rst)
        dec_to_cor.flip |-> (dec_to_cor.flip_idx < IDX_W'(DATA_W)));

endmodule

//--- design/ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_W  = 121;
    localparam int CHECK_W = 9;
    localparam int POS_W   = 7;
    localparam int IDX_W   = 7;

    // syndrome seen as a flat vector or as its Hamming fields
    typedef union packed {
        logic [CHECK_W-1:0] raw;
        struct packed {
            logic             overall;
            logic             ext;
            logic [POS_W-1:0] position;
        } fields;
    } ecc_syndrome_u;

    // true for 1, 2, 4, ... 64
    function automatic logic ecc_is_pow2(input logic [POS_W-1:0] value);
        logic [POS_W-1:0] below;
        below = value - 1'b1;
        return (value != '0) && ((value & below) == '0);
    endfunction

    // Hamming position of data bit idx, skipping the power-of-two slots
    function automatic logic [POS_W-1:0] ecc_position(input logic [IDX_W-1:0] idx);
        logic [POS_W:0] pos;
        pos = {1'b0, idx} + 8'd3;
        for (int k = 2; k < POS_W; k++) begin
            if (pos >= (8'd1 << k)) begin
                pos = pos + 1'b1;
            end
        end
        return pos[POS_W-1:0];
    endfunction

    // check column of one data bit, always of odd weight
    function automatic logic [CHECK_W-1:0] ecc_column(input logic [IDX_W-1:0] idx);
        ecc_syndrome_u col;
        col.raw = '0;
        if (idx == IDX_W'(DATA_W - 1)) begin
            // last bit lives on the extension row
            col.fields.overall  = 1'b1;
            col.fields.ext      = 1'b1;
            col.fields.position = 7'd1;
        end else begin
            col.fields.position = ecc_position(idx);
            col.fields.ext      = 1'b0;
            col.fields.overall  = ~^col.fields.position;
        end
        return col.raw;
    endfunction

    // check bits are the XOR of the columns of all set data bits
    function automatic logic [CHECK_W-1:0] ecc_encode(input logic [DATA_W-1:0] data);
        logic [CHECK_W-1:0] check;
        check = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (data[i]) begin
                check = check ^ ecc_column(IDX_W'(i));
            end
        end
        return check;
    endfunction

    // data-bit index from a Hamming position that is not a power of two
    function automatic logic [IDX_W-1:0] ecc_locate(input logic [POS_W-1:0] position);
        logic [IDX_W-1:0] skipped;
        skipped = '0;
        for (int k = 0; k < POS_W; k++) begin
            // count powers of two at or below the position
            if (position >= POS_W'(1 << k)) begin
                skipped = skipped + 1'b1;
            end
        end
        return position - skipped - 1'b1;
    endfunction

endpackage

//--- design/ecc_stage_if.sv
`timescale 1ns/1ps

interface ecc_stage_if;
    import ecc_pkg::*;

    logic [DATA_W-1:0] data;
    logic              bypass;
    ecc_syndrome_u     syndrome;

    // decode result
    logic              flip;
    logic [IDX_W-1:0]  flip_idx;
    logic              sbit;
    logic              dbit;

    modport source (
        output data, bypass, syndrome, flip, flip_idx, sbit, dbit
    );

    modport sink (
        input data, bypass, syndrome, flip, flip_idx, sbit, dbit
    );

endinterface

//--- design/ecc_syndrome_decoder.sv
`timescale 1ns/1ps

module ecc_syndrome_decoder (
    input  logic        clk,
    input  logic        rst,
    ecc_stage_if.sink   cap_to_dec,
    ecc_stage_if.source dec_to_cor
);
    import ecc_pkg::*;

    ecc_syndrome_u    syn;
    logic             is_zero;
    logic             is_onehot;
    logic             is_last_col;
    logic             is_data_col;
    logic             flip_d;
    logic [IDX_W-1:0] idx_d;
    logic             sbit_d;
    logic             dbit_d;

    assign syn = cap_to_dec.syndrome;

    assign is_zero     = (syn.raw == '0);
    assign is_onehot   = !is_zero && ((syn.raw & (syn.raw - 1'b1)) == '0);
    assign is_last_col = (syn.raw == ecc_column(IDX_W'(DATA_W - 1)));

    // regular columns have ext clear and odd total weight
    assign is_data_col = (syn.fields.position != '0)
                      && !ecc_is_pow2(syn.fields.position)
                      && !syn.fields.ext
                      && (syn.fields.overall == ~^syn.fields.position);

    always_comb begin
        flip_d = 1'b0;
        idx_d  = '0;
        sbit_d = 1'b0;
        dbit_d = 1'b0;
        if (!is_zero) begin
            if (is_onehot) begin
                // only a check bit flipped
                sbit_d = 1'b1;
            end else if (is_last_col) begin
                flip_d = 1'b1;
                idx_d  = IDX_W'(DATA_W - 1);
                sbit_d = 1'b1;
            end else if (is_data_col) begin
                flip_d = 1'b1;
                idx_d  = ecc_locate(syn.fields.position);
                sbit_d = 1'b1;
            end else begin
                dbit_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_to_cor.data     <= '0;
            dec_to_cor.bypass   <= 1'b0;
            dec_to_cor.flip     <= 1'b0;
            dec_to_cor.flip_idx <= '0;
            dec_to_cor.sbit     <= 1'b0;
            dec_to_cor.dbit     <= 1'b0;
        end else begin
            dec_to_cor.data     <= cap_to_dec.data;
            dec_to_cor.bypass   <= cap_to_dec.bypass;
            dec_to_cor.flip     <= flip_d;
            dec_to_cor.flip_idx <= idx_d;
            dec_to_cor.sbit     <= sbit_d;
            dec_to_cor.dbit     <= dbit_d;
        end
    end

    // syndrome is consumed here
    assign dec_to_cor.syndrome.raw = '0;

    // a flip points back at the column that made the syndrome
    a_flip_is_single: assert property (@(posedge clk) disable iff (rst)
        dec_to_cor.flip |-> dec_to_cor.sbit
            && (ecc_column(dec_to_cor.flip_idx) == $past(cap_to_dec.syndrome.raw)));

    // single errors only come from odd-weight syndromes
    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        dec_to_cor.sbit |-> !dec_to_cor.dbit && $past(^cap_to_dec.syndrome.raw));

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ecc_121_tb -f all.f -o ecc_121_sim \
    && ./obj_dir/ecc_121_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/ecc_tb_util.svh
`ifndef ECC_TB_UTIL_SVH
`define ECC_TB_UTIL_SVH

// galois LFSR, right shifting, x^32 + x^30 + x^26 + x^25 + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 32'hA300_0000;
    end
    return next;
endfunction

// one LFSR step per bit handed out
function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    return b;
endfunction

function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < DATA_W; i++) begin
        w[i] = rand_bit();
    end
    return w;
endfunction

function automatic int rand_below(input int limit);
    int v;
    v = 0;
    for (int k = 0; k < 8; k++) begin
        v = (v << 1) | int'(rand_bit());
    end
    return v % limit;
endfunction

// walk the Hamming positions from 3, skipping powers of two
function automatic logic [CHECK_W-1:0] ref_column(input int idx);
    logic [CHECK_W-1:0] col;
    int pos;
    int seen;
    col = '0;
    if (idx == DATA_W - 1) begin
        col[0] = 1'b1;
        col[7] = 1'b1;
        col[8] = 1'b1;
    end else begin
        pos = 2;
        seen = -1;
        while (seen < idx) begin
            pos = pos + 1;
            if ((pos & (pos - 1)) != 0) begin
                seen = seen + 1;
            end
        end
        col[6:0] = pos[6:0];
        // pad to odd weight
        col[8] = ($countones(pos[6:0]) % 2) == 0;
    end
    return col;
endfunction

function automatic logic [CHECK_W-1:0] ref_encode(input logic [DATA_W-1:0] data);
    logic [CHECK_W-1:0] check;
    check = '0;
    for (int i = 0; i < DATA_W; i++) begin
        if (data[i]) begin
            check = check ^ ref_column(i);
        end
    end
    return check;
endfunction

task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
                          input string what);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("Mismatch at %0t ns: %s data_out %h, expected %h", $time, what, got, want);
    end
endtask

task automatic check_parity(input logic [CHECK_W-1:0] got, input logic [CHECK_W-1:0] want,
                            input string what);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("Mismatch at %0t ns: %s parity_out %h, expected %h", $time, what, got, want);
    end
endtask

task automatic check_flags(input logic got_sbit, input logic got_dbit,
                           input logic want_sbit, input logic want_dbit, input string what);
    check_count++;
    if (got_sbit !== want_sbit || got_dbit !== want_dbit) begin
        error_count++;
        $display("Mismatch at %0t ns: %s flags sbit %b dbit %b, expected sbit %b dbit %b",
                 $time, what, got_sbit, got_dbit, want_sbit, want_dbit);
    end
endtask

`endif

//--- tests/ecc_121_tb.sv
`timescale 1ns/1ps

module ecc_121_tb;
    import ecc_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;

    logic               clk;
    logic               rst;
    logic [DATA_W-1:0]  data_in;
    logic [CHECK_W-1:0] parity_in;
    logic               bypass;
    logic [DATA_W-1:0]  data_out;
    logic [CHECK_W-1:0] parity_out;
    logic               sbit_err;
    logic               dbit_err;

    // expected outputs stamped with the cycle the word was driven in
    typedef struct packed {
        logic [31:0]       cycle;
        logic [DATA_W-1:0] data;
        logic              sbit;
        logic              dbit;
    } out_exp_t;

    typedef struct packed {
        logic [31:0]        cycle;
        logic [CHECK_W-1:0] parity;
    } par_exp_t;

    out_exp_t    out_q[$];
    par_exp_t    par_q[$];
    logic [31:0] cycle;
    logic [31:0] lfsr_state;
    logic        timed_out;
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;
    string       test_name;

    `include "ecc_tb_util.svh"

    ecc_121_top DUT (
        .clk        (clk),
        .rst        (rst),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst       = 1'b0;
        // idle inputs from the first cycle out of reset
        data_in   = '0;
        parity_in = '0;
    end

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    // parity is due one cycle after sampling and data and flags three
    always @(negedge clk) begin
        if (!rst) begin
            if (par_q.size() != 0 && par_q[0].cycle + 32'd1 == cycle) begin
                check_parity(parity_out, par_q[0].parity, test_name);
                void'(par_q.pop_front());
            end
            if (out_q.size() != 0 && out_q[0].cycle + 32'd3 == cycle) begin
                check_data(data_out, out_q[0].data, test_name);
                check_flags(sbit_err, dbit_err, out_q[0].sbit, out_q[0].dbit, test_name);
                void'(out_q.pop_front());
            end
        end
    end

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        error_count++;
        $display("Timeout at %0t ns: %s", $time, what);
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst !== 1'b0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            report_timeout("reset was never released");
        end
    endtask

    task automatic send_word(input logic [DATA_W-1:0] data, input logic [CHECK_W-1:0] parity,
                             input logic byp, input logic [DATA_W-1:0] want_data,
                             input logic want_sbit, input logic want_dbit);
        out_exp_t o;
        par_exp_t p;
        if (timed_out) begin
            return;
        end
        @(posedge clk);
        #2;
        data_in   = data;
        parity_in = parity;
        bypass    = byp;
        o.cycle   = cycle;
        o.data    = want_data;
        o.sbit    = want_sbit;
        o.dbit    = want_dbit;
        p.cycle   = cycle;
        p.parity  = ref_encode(data);
        out_q.push_back(o);
        par_q.push_back(p);
    endtask

    // pos below DATA_W hits data and the rest hits check bits
    task automatic inject_error(inout logic [DATA_W-1:0] data,
                                inout logic [CHECK_W-1:0] parity, input int pos);
        if (pos < DATA_W) begin
            data[pos] = ~data[pos];
        end else begin
            parity[pos - DATA_W] = ~parity[pos - DATA_W];
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic end_test();
        int waited;
        if (timed_out) begin
            return;
        end
        @(posedge clk);
        #2;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        waited    = 0;
        while ((out_q.size() != 0 || par_q.size() != 0) && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (out_q.size() != 0 || par_q.size() != 0) begin
            report_timeout("expected words never left the pipeline");
        end
        $display("test %s: %0d checks, %0d errors", test_name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    initial begin
        logic [DATA_W-1:0]  word;
        logic [DATA_W-1:0]  bad;
        logic [CHECK_W-1:0] par;
        int                 a;
        int                 b;

        // a nonzero word that reset must keep out of the pipeline
        data_in     = '1;
        parity_in   = '0;
        bypass      = 1'b0;
        cycle       = '0;
        lfsr_state  = 32'd77216;
        timed_out   = 1'b0;
        check_count = 0;
        error_count = 0;
        test_name   = "startup";

        wait_reset_release();

        begin_test("reset");
        check_data(data_out, '0, test_name);
        check_parity(parity_out, '0, test_name);
        check_flags(sbit_err, dbit_err, 1'b0, 1'b0, test_name);
        word = rand_word();
        send_word(word, ref_encode(word), 1'b0, word, 1'b0, 1'b0);
        // nothing reaches data_out for three edges
        repeat (3) begin
            @(negedge clk);
            check_data(data_out, '0, test_name);
            check_flags(sbit_err, dbit_err, 1'b0, 1'b0, test_name);
        end
        end_test();

        begin_test("clean_words");
        repeat (40) begin
            word = rand_word();
            send_word(word, ref_encode(word), 1'b0, word, 1'b0, 1'b0);
        end
        end_test();

        begin_test("single_data_error");
        for (int i = 0; i < DATA_W; i++) begin
            word = rand_word();
            bad  = word ^ (DATA_W'(1) << i);
            send_word(bad, ref_encode(word), 1'b0, word, 1'b1, 1'b0);
        end
        end_test();

        begin_test("single_check_error");
        for (int i = 0; i < CHECK_W; i++) begin
            word = rand_word();
            par  = ref_encode(word) ^ (CHECK_W'(1) << i);
            send_word(word, par, 1'b0, word, 1'b1, 1'b0);
        end
        end_test();

        begin_test("double_error");
        repeat (40) begin
            word = rand_word();
            par  = ref_encode(word);
            a    = rand_below(DATA_W + CHECK_W);
            b    = rand_below(DATA_W + CHECK_W - 1);
            if (b >= a) begin
                b = b + 1;
            end
            inject_error(word, par, a);
            inject_error(word, par, b);
            send_word(word, par, 1'b0, word, 1'b0, 1'b1);
        end
        end_test();

        begin_test("bypass");
        repeat (20) begin
            word = rand_word();
            par  = ref_encode(word);
            a    = rand_below(DATA_W + CHECK_W);
            inject_error(word, par, a);
            if (rand_bit()) begin
                b = rand_below(DATA_W + CHECK_W - 1);
                if (b >= a) begin
                    b = b + 1;
                end
                inject_error(word, par, b);
            end
            send_word(word, par, 1'b1, word, 1'b0, 1'b0);
        end
        end_test();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
